//--- logic/csr_addr_pkg.sv
`default_nettype none

package csr_addr_pkg;

    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] csr_data_t;

    localparam csr_num_t CSR_CRMD      = 14'd0;
    localparam csr_num_t CSR_PRMD      = 14'd1;
    localparam csr_num_t CSR_EUEN      = 14'd2;
    localparam csr_num_t CSR_ECTL      = 14'd4;
    localparam csr_num_t CSR_ESTAT     = 14'd5;
    localparam csr_num_t CSR_ERA       = 14'd6;
    localparam csr_num_t CSR_BADV      = 14'd7;
    localparam csr_num_t CSR_EENTRY    = 14'd12;
    localparam csr_num_t CSR_SAVE_BASE = 14'd48;  // save0 .. save3

    typedef enum logic [3:0] {
        SEL_CRMD,
        SEL_PRMD,
        SEL_EUEN,
        SEL_ECTL,
        SEL_ESTAT,
        SEL_ERA,
        SEL_BADV,
        SEL_EENTRY,
        SEL_SAVE,
        SEL_NONE
    } csr_sel_t;

    typedef struct packed {
        csr_sel_t   sel;
        logic [1:0] idx;  // save index, zero otherwise
    } csr_sel_word_t;

    localparam csr_data_t MASK_CRMD   = 32'h0000_01ff;
    localparam csr_data_t MASK_PRMD   = 32'h0000_0007;
    localparam csr_data_t MASK_EUEN   = 32'h0000_0001;
    localparam csr_data_t MASK_ECTL   = 32'h0000_1bff;  // bit 10 reserved
    localparam csr_data_t MASK_ESTAT  = 32'h0000_0003;  // sw interrupt bits only
    localparam csr_data_t MASK_ERA    = 32'hffff_ffff;
    localparam csr_data_t MASK_BADV   = 32'hffff_ffff;
    localparam csr_data_t MASK_EENTRY = 32'hffff_ffc0;  // 64 byte aligned
    localparam csr_data_t MASK_SAVE   = 32'hffff_ffff;

    localparam int CRMD_PLV_LSB       = 0;  // 2 bits
    localparam int CRMD_IE_BIT        = 2;
    localparam int CRMD_DA_BIT        = 3;
    localparam int PRMD_PPLV_LSB      = 0;  // 2 bits
    localparam int PRMD_PIE_BIT       = 2;
    localparam int ESTAT_IS_LSB       = 0;
    localparam int ESTAT_IS_W         = 13;
    localparam int ESTAT_HWI_LSB      = 2;  // hw lines land in is[9:2]
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;
    localparam int ECTL_LIE_LSB       = 0;
    localparam int ECTL_LIE_W         = 13;

    typedef struct packed {
        logic          valid;
        csr_sel_word_t sel;
        csr_data_t     data;
        csr_data_t     mask;  // caller mask and writable mask combined
    } csr_wr_t;

endpackage

`default_nettype wire

//--- logic/trap_pkg.sv
`default_nettype none

package trap_pkg;

    localparam int N_SLOTS = 2;

    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

    localparam ecode_t ECODE_INT  = 6'h00;
    localparam ecode_t ECODE_PIL  = 6'h01;
    localparam ecode_t ECODE_PIS  = 6'h02;
    localparam ecode_t ECODE_PIF  = 6'h03;
    localparam ecode_t ECODE_PME  = 6'h04;
    localparam ecode_t ECODE_PPI  = 6'h07;
    localparam ecode_t ECODE_ADEF = 6'h08;
    localparam ecode_t ECODE_ADEM = 6'h08;  // same code as adef, told apart by esubcode
    localparam ecode_t ECODE_ALE  = 6'h09;
    localparam ecode_t ECODE_SYS  = 6'h0b;
    localparam ecode_t ECODE_BRK  = 6'h0c;

    typedef struct packed {
        logic        excp;
        logic        ertn;
        ecode_t      ecode;
        esubcode_t   esubcode;
        logic [31:0] pc;
        logic [31:0] bad_va;
    } trap_req_t;

    typedef enum logic [1:0] {
        TRAP_NONE,
        TRAP_INT,
        TRAP_EXCP,
        TRAP_ERTN
    } trap_kind_t;

    typedef struct packed {
        trap_kind_t  kind;
        ecode_t      ecode;
        esubcode_t   esubcode;
        logic [31:0] era;
        logic        badv_we;
        logic [31:0] bad_va;
        logic [1:0]  flush;  // 11 both slots, 01 slot 0 only
    } trap_commit_t;

endpackage

`default_nettype wire

//--- logic/csr_access.sv
`default_nettype none

module csr_access #(
    parameter int N_SAVE = 4
) (
    input  csr_addr_pkg::csr_num_t      rd_num_i,
    input  logic                        wr_en_i,
    input  csr_addr_pkg::csr_num_t      wr_num_i,
    input  csr_addr_pkg::csr_data_t     wr_data_i,
    input  csr_addr_pkg::csr_data_t     wr_mask_i,
    output csr_addr_pkg::csr_sel_word_t rd_sel_o,
    output csr_addr_pkg::csr_wr_t       wr_o
);
    import csr_addr_pkg::*;

    csr_sel_word_t wr_sel;

    function automatic csr_sel_word_t decode(input csr_num_t num);
        csr_sel_word_t res;
        csr_num_t      offs;
        offs = num - CSR_SAVE_BASE;
        res.idx = offs[1:0];
        case (num)
            CSR_CRMD:   res.sel = SEL_CRMD;
            CSR_PRMD:   res.sel = SEL_PRMD;
            CSR_EUEN:   res.sel = SEL_EUEN;
            CSR_ECTL:   res.sel = SEL_ECTL;
            CSR_ESTAT:  res.sel = SEL_ESTAT;
            CSR_ERA:    res.sel = SEL_ERA;
            CSR_BADV:   res.sel = SEL_BADV;
            CSR_EENTRY: res.sel = SEL_EENTRY;
            default: begin
                // below the base offs wraps to a large value
                res.sel = (offs < csr_num_t'(N_SAVE)) ? SEL_SAVE : SEL_NONE;
            end
        endcase
        if (res.sel != SEL_SAVE) begin
            res.idx = '0;
        end
        return res;
    endfunction

    function automatic csr_data_t writable(input csr_sel_t sel);
        csr_data_t m;
        case (sel)
            SEL_CRMD:   m = MASK_CRMD;
            SEL_PRMD:   m = MASK_PRMD;
            SEL_EUEN:   m = MASK_EUEN;
            SEL_ECTL:   m = MASK_ECTL;
            SEL_ESTAT:  m = MASK_ESTAT;
            SEL_ERA:    m = MASK_ERA;
            SEL_BADV:   m = MASK_BADV;
            SEL_EENTRY: m = MASK_EENTRY;
            SEL_SAVE:   m = MASK_SAVE;
            default:    m = '0;
        endcase
        return m;
    endfunction

    assign rd_sel_o = decode(rd_num_i);
    assign wr_sel   = decode(wr_num_i);

    always_comb begin
        wr_o.valid = wr_en_i && (wr_sel.sel != SEL_NONE);  // unknown numbers dropped
        wr_o.sel   = wr_sel;
        wr_o.data  = wr_data_i;
        wr_o.mask  = wr_mask_i & writable(wr_sel.sel);
    end

endmodule

`default_nettype wire

//--- logic/trap_arbiter.sv
`default_nettype none

module trap_arbiter (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  trap_pkg::trap_req_t [trap_pkg::N_SLOTS-1:0]    slot_i,
    input  logic                                           int_pending_i,
    input  csr_addr_pkg::csr_data_t                        era_i,
    output trap_pkg::trap_commit_t                         commit_o
);
    import trap_pkg::*;

    logic [N_SLOTS-1:0] both_req;

    always_comb begin
        logic found;
        commit_o      = '0;
        commit_o.kind = TRAP_NONE;
        commit_o.era  = era_i;  // ertn and idle keep era
        found         = int_pending_i;

        if (int_pending_i) begin
            commit_o.kind     = TRAP_INT;
            commit_o.ecode    = ECODE_INT;
            commit_o.esubcode = '0;
            commit_o.era      = slot_i[N_SLOTS-1].pc;  // older slot resumes
            commit_o.flush    = 2'b11;
        end

        // oldest slot first and exception ahead of ertn within a slot
        for (int s = N_SLOTS - 1; s >= 0; s--) begin
            if (!found && slot_i[s].excp) begin
                commit_o.kind     = TRAP_EXCP;
                commit_o.ecode    = slot_i[s].ecode;
                commit_o.esubcode = slot_i[s].esubcode;
                commit_o.era      = slot_i[s].pc;
                commit_o.bad_va   = slot_i[s].bad_va;
                commit_o.flush    = (s == N_SLOTS - 1) ? 2'b11 : 2'b01;
                found             = 1'b1;
            end else if (!found && slot_i[s].ertn) begin
                commit_o.kind  = TRAP_ERTN;
                commit_o.flush = (s == N_SLOTS - 1) ? 2'b11 : 2'b01;
                found          = 1'b1;
            end
        end

        commit_o.badv_we = (commit_o.kind == TRAP_EXCP) &&
                           (commit_o.ecode inside {ECODE_ADEF, ECODE_ADEM, ECODE_ALE,
                                                   ECODE_PIL, ECODE_PIS, ECODE_PIF,
                                                   ECODE_PME, ECODE_PPI});
    end

    always_comb begin
        for (int s = 0; s < N_SLOTS; s++) begin
            both_req[s] = slot_i[s].excp && slot_i[s].ertn;
        end
    end

    // a slot retires at most one of exception and ertn
    a_slot_single: assert property (@(posedge clk) disable iff (!rst_n)
        both_req == '0)
        else $error("trap_arbiter: slot with both excp and ertn %b", both_req);

endmodule

`default_nettype wire

//--- logic/csr_regfile.sv
`default_nettype none

module csr_regfile #(
    parameter int N_SAVE = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  csr_addr_pkg::csr_wr_t       wr_i,
    input  csr_addr_pkg::csr_sel_word_t rd_sel_i,
    input  trap_pkg::trap_commit_t      commit_i,
    input  logic [7:0]                  int_i,
    output csr_addr_pkg::csr_data_t     rd_data_o,
    output logic                        int_pending_o,
    output csr_addr_pkg::csr_data_t     era_o,
    output logic                        redirect_o,
    output csr_addr_pkg::csr_data_t     redirect_addr_o,
    output logic [1:0]                  flush_o
);
    import csr_addr_pkg::*;
    import trap_pkg::*;

    csr_data_t crmd_q;
    csr_data_t prmd_q;
    csr_data_t euen_q;
    csr_data_t ectl_q;
    csr_data_t estat_q;
    csr_data_t era_q;
    csr_data_t badv_q;
    csr_data_t eentry_q;
    csr_data_t save_q [N_SAVE];

    logic sw_we;
    logic entry;
    logic ertn;

    function automatic csr_data_t merge(input csr_data_t old, input csr_wr_t wr);
        return (old & ~wr.mask) | (wr.data & wr.mask);
    endfunction

    assign sw_we = wr_i.valid && (commit_i.kind == TRAP_NONE);  // trap wins over sw write
    assign entry = (commit_i.kind == TRAP_INT) || (commit_i.kind == TRAP_EXCP);
    assign ertn  = commit_i.kind == TRAP_ERTN;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd_q              <= '0;
            crmd_q[CRMD_DA_BIT] <= 1'b1;
            prmd_q              <= '0;
            euen_q              <= '0;
            ectl_q              <= '0;
            estat_q             <= '0;
            era_q               <= '0;
            badv_q              <= '0;
            eentry_q            <= '0;
            for (int i = 0; i < N_SAVE; i++) begin
                save_q[i] <= '0;
            end
        end else begin
            if (sw_we) begin
                case (wr_i.sel.sel)
                    SEL_CRMD:   crmd_q   <= merge(crmd_q, wr_i);
                    SEL_PRMD:   prmd_q   <= merge(prmd_q, wr_i);
                    SEL_EUEN:   euen_q   <= merge(euen_q, wr_i);
                    SEL_ECTL:   ectl_q   <= merge(ectl_q, wr_i);
                    SEL_ESTAT:  estat_q  <= merge(estat_q, wr_i);
                    SEL_ERA:    era_q    <= merge(era_q, wr_i);
                    SEL_BADV:   badv_q   <= merge(badv_q, wr_i);
                    SEL_EENTRY: eentry_q <= merge(eentry_q, wr_i);
                    SEL_SAVE:   save_q[wr_i.sel.idx] <= merge(save_q[wr_i.sel.idx], wr_i);
                    default:    ;
                endcase
            end
            if (entry) begin
                prmd_q[PRMD_PPLV_LSB +: 2] <= crmd_q[CRMD_PLV_LSB +: 2];
                prmd_q[PRMD_PIE_BIT]       <= crmd_q[CRMD_IE_BIT];
                crmd_q[CRMD_PLV_LSB +: 2]  <= 2'b00;  // kernel with interrupts off
                crmd_q[CRMD_IE_BIT]        <= 1'b0;
                era_q                      <= commit_i.era;
                estat_q[ESTAT_ECODE_LSB +: $bits(ecode_t)]       <= commit_i.ecode;
                estat_q[ESTAT_ESUBCODE_LSB +: $bits(esubcode_t)] <= commit_i.esubcode;
                if (commit_i.badv_we) begin
                    badv_q <= commit_i.bad_va;
                end
            end
            if (ertn) begin
                crmd_q[CRMD_PLV_LSB +: 2] <= prmd_q[PRMD_PPLV_LSB +: 2];
                crmd_q[CRMD_IE_BIT]       <= prmd_q[PRMD_PIE_BIT];
            end
            estat_q[ESTAT_HWI_LSB +: 8] <= int_i;  // sampled every cycle
        end
    end

    always_comb begin
        case (rd_sel_i.sel)
            SEL_CRMD:   rd_data_o = crmd_q;
            SEL_PRMD:   rd_data_o = prmd_q;
            SEL_EUEN:   rd_data_o = euen_q;
            SEL_ECTL:   rd_data_o = ectl_q;
            SEL_ESTAT:  rd_data_o = estat_q;
            SEL_ERA:    rd_data_o = era_q;
            SEL_BADV:   rd_data_o = badv_q;
            SEL_EENTRY: rd_data_o = eentry_q;
            SEL_SAVE:   rd_data_o = save_q[rd_sel_i.idx];
            default:    rd_data_o = '0;
        endcase
    end

    assign int_pending_o = (|(estat_q[ESTAT_IS_LSB +: ESTAT_IS_W] &
                              ectl_q[ECTL_LIE_LSB +: ECTL_LIE_W])) && crmd_q[CRMD_IE_BIT];

    assign era_o           = era_q;
    assign redirect_o      = commit_i.kind != TRAP_NONE;
    assign redirect_addr_o = ertn ? era_q : eentry_q;
    assign flush_o         = commit_i.flush;

    a_redirect_flush: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o |-> (flush_o != 2'b00))
        else $error("csr_regfile: redirect without flush");

    // interrupt commits only while one is pending here
    a_int_pending: assert property (@(posedge clk) disable iff (!rst_n)
        (commit_i.kind == TRAP_INT) |-> int_pending_o)
        else $error("csr_regfile: interrupt commit without a pending interrupt");

endmodule

`default_nettype wire

//--- logic/csr_top.sv
`default_nettype none

module csr_top #(
    parameter int N_SAVE = 4
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  csr_addr_pkg::csr_num_t                         rd_num_i,
    output csr_addr_pkg::csr_data_t                        rd_data_o,
    input  logic                                           wr_en_i,
    input  csr_addr_pkg::csr_num_t                         wr_num_i,
    input  csr_addr_pkg::csr_data_t                        wr_data_i,
    input  csr_addr_pkg::csr_data_t                        wr_mask_i,
    input  trap_pkg::trap_req_t [trap_pkg::N_SLOTS-1:0]    slot_i,
    input  logic [7:0]                                     int_i,
    output logic                                           redirect_o,
    output csr_addr_pkg::csr_data_t                        redirect_addr_o,
    output logic [1:0]                                     flush_o
);
    import csr_addr_pkg::*;
    import trap_pkg::*;

    csr_wr_t       wr;
    csr_sel_word_t rd_sel;
    trap_commit_t  commit;
    logic          int_pending;
    csr_data_t     era;

    csr_access #(
        .N_SAVE    (N_SAVE)
    ) u_access (
        .rd_num_i  (rd_num_i),
        .wr_en_i   (wr_en_i),
        .wr_num_i  (wr_num_i),
        .wr_data_i (wr_data_i),
        .wr_mask_i (wr_mask_i),
        .rd_sel_o  (rd_sel),
        .wr_o      (wr)
    );

    trap_arbiter u_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .slot_i        (slot_i),
        .int_pending_i (int_pending),
        .era_i         (era),
        .commit_o      (commit)
    );

    csr_regfile #(
        .N_SAVE          (N_SAVE)
    ) u_regfile (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr_i            (wr),
        .rd_sel_i        (rd_sel),
        .commit_i        (commit),
        .int_i           (int_i),
        .rd_data_o       (rd_data_o),
        .int_pending_o   (int_pending),
        .era_o           (era),
        .redirect_o      (redirect_o),
        .redirect_addr_o (redirect_addr_o),
        .flush_o         (flush_o)
    );

endmodule

`default_nettype wire

//--- verif/tb_csr_checks.svh
`ifndef TB_CSR_CHECKS_SVH
`define TB_CSR_CHECKS_SVH

    logic       chk_rd = 1'b0;    // compare rd_data_o this cycle
    csr_data_t  exp_rd_data = '0;
    logic       chk_trap = 1'b0;  // compare redirect and flush this cycle
    logic       exp_redirect = 1'b0;
    csr_data_t  exp_addr = '0;
    logic [1:0] exp_flush = 2'b00;
    int         errors = 0;
    int         n_reads = 0;
    int         n_traps = 0;

    csr_data_t  m_save [4];  // shadow of the save registers
    csr_data_t  m_eentry;

    // esubcode in 30:22, ecode in 21:16, is in 12:0
    function automatic csr_data_t estat_code(input ecode_t code, input esubcode_t sub);
        return {1'b0, sub, code, 16'h0000};
    endfunction

    a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
        chk_rd |-> (rd_data_o == exp_rd_data))
        else begin
            errors = errors + 1;
            $display("mismatch rd_data_o (csr %h): got %h expected %h",
                     $sampled(rd_num_i), $sampled(rd_data_o), exp_rd_data);
        end

    a_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        chk_trap |-> (redirect_o == exp_redirect))
        else begin
            errors = errors + 1;
            $display("mismatch redirect_o: got %h expected %h",
                     $sampled(redirect_o), exp_redirect);
        end

    a_flush: assert property (@(posedge clk) disable iff (!rst_n)
        chk_trap |-> (flush_o == exp_flush))
        else begin
            errors = errors + 1;
            $display("mismatch flush_o: got %h expected %h", $sampled(flush_o), exp_flush);
        end

    a_redirect_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (chk_trap && exp_redirect) |-> (redirect_addr_o == exp_addr))
        else begin
            errors = errors + 1;
            $display("mismatch redirect_addr_o: got %h expected %h",
                     $sampled(redirect_addr_o), exp_addr);
        end

`endif

//--- verif/tb_csr_top.sv
`default_nettype none

module tb_csr_top;
    timeunit 1ns;
    timeprecision 100ps;

    import csr_addr_pkg::*;
    import trap_pkg::*;

    localparam int          SCRIPT_CYCLES = 62;  // reset plus every scripted step
    localparam logic [31:0] PC0 = 32'h1c00_0100;
    localparam logic [31:0] PC1 = 32'h1c00_0204;
    localparam logic [31:0] PC2 = 32'h1c00_0300;
    localparam logic [31:0] PC3 = 32'h1c00_0408;
    localparam logic [31:0] VA0 = 32'h8000_1235;
    localparam logic [31:0] VA1 = 32'h0000_0bad;

    logic                    clk = 1'b0;
    logic                    rst_n;
    csr_num_t                rd_num_i;
    csr_data_t               rd_data_o;
    logic                    wr_en_i;
    csr_num_t                wr_num_i;
    csr_data_t               wr_data_i;
    csr_data_t               wr_mask_i;
    trap_req_t [N_SLOTS-1:0] slot_i;
    logic [7:0]              int_i;
    logic                    redirect_o;
    csr_data_t               redirect_addr_o;
    logic [1:0]              flush_o;
    int                      seed = 1;

    always #2 clk = ~clk;

    csr_top #(
        .N_SAVE          (4)
    ) u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_num_i        (rd_num_i),
        .rd_data_o       (rd_data_o),
        .wr_en_i         (wr_en_i),
        .wr_num_i        (wr_num_i),
        .wr_data_i       (wr_data_i),
        .wr_mask_i       (wr_mask_i),
        .slot_i          (slot_i),
        .int_i           (int_i),
        .redirect_o      (redirect_o),
        .redirect_addr_o (redirect_addr_o),
        .flush_o         (flush_o)
    );

    `include "tb_csr_checks.svh"

    // one clock, then drop the one-shot inputs and checks
    task automatic next_cycle;
        @(posedge clk);
        #1;
        wr_en_i  = 1'b0;
        slot_i   = '0;
        chk_rd   = 1'b0;
        chk_trap = 1'b0;
    endtask

    task automatic watch_read(input csr_num_t num, input csr_data_t val);
        rd_num_i    = num;
        exp_rd_data = val;
        chk_rd      = 1'b1;
        n_reads     = n_reads + 1;
    endtask

    task automatic expect_read(input csr_num_t num, input csr_data_t val);
        watch_read(num, val);
        next_cycle();
    endtask

    task automatic write_csr(input csr_num_t num, input csr_data_t data, input csr_data_t mask);
        wr_en_i   = 1'b1;
        wr_num_i  = num;
        wr_data_i = data;
        wr_mask_i = mask;
        next_cycle();
    endtask

    task automatic post_trap(input int s, input logic is_ertn, input ecode_t code,
                             input esubcode_t sub, input logic [31:0] pc,
                             input logic [31:0] va);
        slot_i[s].excp     = !is_ertn;
        slot_i[s].ertn     = is_ertn;
        slot_i[s].ecode    = code;
        slot_i[s].esubcode = sub;
        slot_i[s].pc       = pc;
        slot_i[s].bad_va   = va;
    endtask

    task automatic expect_redirect(input csr_data_t addr, input logic [1:0] flush);
        chk_trap     = 1'b1;
        exp_redirect = 1'b1;
        exp_addr     = addr;
        exp_flush    = flush;
        n_traps      = n_traps + 1;
        next_cycle();
    endtask

    task automatic expect_quiet;
        chk_trap     = 1'b1;
        exp_redirect = 1'b0;
        exp_flush    = 2'b00;
        next_cycle();
    endtask

    initial begin
        csr_data_t v;
        csr_data_t m;
        rst_n     = 1'b0;
        rd_num_i  = '0;
        wr_en_i   = 1'b0;
        wr_num_i  = '0;
        wr_data_i = '0;
        wr_mask_i = '0;
        slot_i    = '0;
        int_i     = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        expect_read(CSR_CRMD, 32'h0000_0008);  // only da set
        expect_read(CSR_PRMD, 32'h0);
        expect_read(CSR_EUEN, 32'h0);
        expect_read(CSR_ECTL, 32'h0);
        expect_read(CSR_ESTAT, 32'h0);
        expect_read(CSR_ERA, 32'h0);
        expect_read(CSR_BADV, 32'h0);
        expect_read(CSR_EENTRY, 32'h0);
        for (int i = 0; i < 4; i++) begin
            expect_read(csr_num_t'(CSR_SAVE_BASE + i), 32'h0);
        end
        for (int i = 0; i < 4; i++) begin
            m_save[i] = $random(seed);
            write_csr(csr_num_t'(CSR_SAVE_BASE + i), m_save[i], 32'hffff_ffff);
        end
        for (int i = 0; i < 4; i++) begin
            expect_read(csr_num_t'(CSR_SAVE_BASE + i), m_save[i]);
        end
        v = $random(seed);
        m_eentry = v & 32'hffff_ffc0;  // entry is 64 byte aligned
        write_csr(CSR_EENTRY, v, 32'hffff_ffff);
        expect_read(CSR_EENTRY, m_eentry);
        v = $random(seed);
        m = $random(seed);
        write_csr(CSR_SAVE_BASE, v, m);  // exchange
        m_save[0] = (m_save[0] & ~m) | (v & m);
        expect_read(CSR_SAVE_BASE, m_save[0]);
        expect_read(14'd3, 32'h0);
        expect_read(14'h3fff, 32'h0);
        expect_read(csr_num_t'(CSR_SAVE_BASE + 4), 32'h0);

        // slot 0 syscall from plv 3 with interrupts on
        write_csr(CSR_CRMD, 32'h0000_0007, 32'h0000_0007);
        wr_en_i   = 1'b1;  // loses against the trap
        wr_num_i  = csr_num_t'(CSR_SAVE_BASE + 1);
        wr_data_i = ~m_save[1];
        wr_mask_i = 32'hffff_ffff;
        post_trap(0, 1'b0, ECODE_SYS, 9'd0, PC0, 32'h0);
        expect_redirect(m_eentry, 2'b01);
        expect_read(CSR_ERA, PC0);
        expect_read(CSR_ESTAT, estat_code(ECODE_SYS, 9'd0));
        expect_read(CSR_CRMD, 32'h0000_0008);
        expect_read(CSR_PRMD, 32'h0000_0007);
        expect_read(csr_num_t'(CSR_SAVE_BASE + 1), m_save[1]);

        post_trap(0, 1'b1, ECODE_INT, 9'd0, PC2, 32'h0);  // ertn
        expect_redirect(PC0, 2'b01);
        expect_read(CSR_CRMD, 32'h0000_000f);
        expect_read(CSR_PRMD, 32'h0000_0007);

        // slot 1 is older and wins
        post_trap(0, 1'b0, ECODE_SYS, 9'd0, PC2, 32'h0);
        post_trap(1, 1'b0, ECODE_BRK, 9'd0, PC1, 32'h0);
        expect_redirect(m_eentry, 2'b11);
        expect_read(CSR_ERA, PC1);
        expect_read(CSR_ESTAT, estat_code(ECODE_BRK, 9'd0));
        post_trap(0, 1'b1, ECODE_INT, 9'd0, PC2, 32'h0);
        post_trap(1, 1'b0, ECODE_SYS, 9'd0, PC3, 32'h0);
        expect_redirect(m_eentry, 2'b11);
        expect_read(CSR_ERA, PC3);
        expect_read(CSR_ESTAT, estat_code(ECODE_SYS, 9'd0));

        post_trap(0, 1'b0, ECODE_ADEM, 9'd1, PC0, VA0);
        expect_redirect(m_eentry, 2'b01);
        expect_read(CSR_BADV, VA0);
        expect_read(CSR_ESTAT, estat_code(ECODE_ADEM, 9'd1));
        post_trap(0, 1'b0, ECODE_SYS, 9'd0, PC0, VA1);
        expect_redirect(m_eentry, 2'b01);
        expect_read(CSR_BADV, VA0);  // sys leaves badv alone

        // hw line 0 lands in is bit 2
        write_csr(CSR_ECTL, 32'h0000_0004, 32'hffff_ffff);
        write_csr(CSR_CRMD, 32'h0000_0004, 32'h0000_0004);
        int_i = 8'h01;
        expect_quiet();
        watch_read(CSR_ESTAT, estat_code(ECODE_SYS, 9'd0) | 32'h0000_0004);
        expect_redirect(m_eentry, 2'b11);
        watch_read(CSR_ESTAT, estat_code(ECODE_INT, 9'd0) | 32'h0000_0004);
        expect_quiet();
        repeat (3) expect_quiet();
        expect_read(CSR_CRMD, 32'h0000_0008);
        expect_read(CSR_PRMD, 32'h0000_0004);
        expect_read(CSR_ERA, 32'h0);  // idle slot 1 pc
        int_i = 8'h00;
        next_cycle();

        $display("reads checked %0d, redirects checked %0d, errors %0d",
                 n_reads, n_traps, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(4 * SCRIPT_CYCLES + 100);
        $display("watchdog expired, the script did not finish in %0d ns",
                 4 * SCRIPT_CYCLES + 100);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+verif
logic/csr_addr_pkg.sv
logic/trap_pkg.sv
logic/csr_access.sv
logic/trap_arbiter.sv
logic/csr_regfile.sv
logic/csr_top.sv
verif/tb_csr_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the CSR block testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert -f src.f --top-module tb_csr_top -o sim_csr

./obj_dir/sim_csr | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

echo "simulation finished without failures"
